/* build.f */
+incdir+test
hw/pixelPkg.sv
hw/layerBus.sv
hw/bgFetch.sv
hw/tankSprite.sv
hw/bulletSprite.sv
hw/palette.sv
hw/layerMixer.sv
hw/colorMapper.sv
test/tbColorMapper.sv

/* hw/bgFetch.sv */
// background fetch, word address into the packed nibble memory and registered colour index
`timescale 1ns/10ps

module bgFetch (
	input logic VGA_Clk,
	input logic Reset,
	input pixelPkg::coord_t drawX,
	input pixelPkg::coord_t drawY,
	input logic [7:0] bgData,
	output logic [pixelPkg::BgAddrW-1:0] bgAddr,
	output pixelPkg::colorIdx_t bgIdx
);
	import pixelPkg::*;

	logic [BgAddrW-1:0] rowBase;
	colorIdx_t nibble;

	// half-res rows, so every screen row pair shares one memory row
	assign rowBase = BgAddrW'(drawY[CoordW-1:1] * BgRowWords);
	assign bgAddr = rowBase + BgAddrW'(drawX[CoordW-1:2]);

	// left half-res pixel sits in the upper nibble
	assign nibble = drawX[1] ? bgData[3:0] : bgData[7:4];

	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset) begin
			bgIdx <= KeyIdx;
		end else begin
			bgIdx <= nibble;
		end
	end

endmodule

/* hw/bulletSprite.sv */
// bullet sprite, box hit test and procedural rounded square
`timescale 1ns/10ps

module bulletSprite (
	input logic VGA_Clk,
	input logic Reset,
	input pixelPkg::coord_t drawX,
	input pixelPkg::coord_t drawY,
	input pixelPkg::coord_t bulletX,
	input pixelPkg::coord_t bulletY,
	input pixelPkg::tankKind_t tankKind,
	output pixelPkg::colorIdx_t bulletIdx
);
	import pixelPkg::*;

	logic [CoordW:0] dx;
	logic [CoordW:0] dy;
	logic inBox;
	logic [2:0] bx;
	logic [2:0] by;
	logic corner;
	colorIdx_t shapeIdx;

	assign dx = {1'b0, drawX} - {1'b0, bulletX};
	assign dy = {1'b0, drawY} - {1'b0, bulletY};
	assign inBox = !dx[CoordW] && !dy[CoordW] && (dx < BulletSize) && (dy < BulletSize);

	assign bx = dx[2:0];
	assign by = dy[2:0];

	// knock out the four corners to round it off
	assign corner = (bx == 3'd0 || bx == 3'(BulletSize - 1))
		&& (by == 3'd0 || by == 3'(BulletSize - 1));

	// shell colour follows the tank model that fired it
	always_comb begin
		shapeIdx = KeyIdx;
		if (inBox && !corner) begin
			shapeIdx = 4'd9 + colorIdx_t'(tankKind);
		end
	end

	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset) begin
			bulletIdx <= KeyIdx;
		end else begin
			bulletIdx <= shapeIdx;
		end
	end

endmodule

/* hw/colorMapper.sv */
// colour mapper top, background and sprite layers feeding the mixer
`timescale 1ns/10ps

module colorMapper (
	input logic VGA_Clk,
	input logic Reset,
	input pixelPkg::coord_t DrawX,
	input pixelPkg::coord_t DrawY,
	input logic blank,
	input pixelPkg::gameState_e gameState,
	input pixelPkg::coord_t TankX_A,
	input pixelPkg::coord_t TankY_A,
	input pixelPkg::coord_t TankX_B,
	input pixelPkg::coord_t TankY_B,
	input pixelPkg::coord_t BulletX_A,
	input pixelPkg::coord_t BulletY_A,
	input pixelPkg::coord_t BulletX_B,
	input pixelPkg::coord_t BulletY_B,
	input pixelPkg::facing_e facingA,
	input pixelPkg::facing_e facingB,
	input pixelPkg::tankKind_t tankKindA,
	input pixelPkg::tankKind_t tankKindB,
	input logic [7:0] bgData,
	output logic [pixelPkg::BgAddrW-1:0] bgAddr,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue
);

	layerBus layers ();

	// ----------------------------------------
	// layer producers
	// ----------------------------------------
	bgFetch bgStage (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.drawX(DrawX),
		.drawY(DrawY),
		.bgData(bgData),
		.bgAddr(bgAddr),
		.bgIdx(layers.bgIdx)
	);

	tankSprite tankA (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.drawX(DrawX),
		.drawY(DrawY),
		.tankX(TankX_A),
		.tankY(TankY_A),
		.facing(facingA),
		.tankKind(tankKindA),
		.tankIdx(layers.tankAIdx)
	);

	tankSprite tankB (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.drawX(DrawX),
		.drawY(DrawY),
		.tankX(TankX_B),
		.tankY(TankY_B),
		.facing(facingB),
		.tankKind(tankKindB),
		.tankIdx(layers.tankBIdx)
	);

	// each bullet takes its shell colour from its own tank
	bulletSprite bulletA (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.drawX(DrawX),
		.drawY(DrawY),
		.bulletX(BulletX_A),
		.bulletY(BulletY_A),
		.tankKind(tankKindA),
		.bulletIdx(layers.bulletAIdx)
	);

	bulletSprite bulletB (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.drawX(DrawX),
		.drawY(DrawY),
		.bulletX(BulletX_B),
		.bulletY(BulletY_B),
		.tankKind(tankKindB),
		.bulletIdx(layers.bulletBIdx)
	);

	// ----------------------------------------
	// mixer
	// ----------------------------------------
	layerMixer mixer (
		.VGA_Clk(VGA_Clk),
		.Reset(Reset),
		.gameState(gameState),
		.blank(blank),
		.drawX(DrawX),
		.layers(layers.mixer),
		.Red(Red),
		.Green(Green),
		.Blue(Blue)
	);

endmodule

/* hw/layerBus.sv */
// layer bus carrying the five registered colour-index layers into the mixer
`timescale 1ns/10ps

interface layerBus;
	import pixelPkg::*;

	// zero in any member means nothing drawn in that layer
	colorIdx_t bgIdx;
	colorIdx_t tankAIdx;
	colorIdx_t tankBIdx;
	colorIdx_t bulletAIdx;
	colorIdx_t bulletBIdx;

	modport mixer (
		input bgIdx, tankAIdx, tankBIdx, bulletAIdx, bulletBIdx
	);

	modport producers (
		output bgIdx, tankAIdx, tankBIdx, bulletAIdx, bulletBIdx
	);

endinterface

/* hw/layerMixer.sv */
// layer mixer, per-state layer priority, blanking, palette lookup and registered RGB
`timescale 1ns/10ps

module layerMixer (
	input logic VGA_Clk,
	input logic Reset,
	input pixelPkg::gameState_e gameState,
	input logic blank,
	input pixelPkg::coord_t drawX,
	layerBus.mixer layers,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue
);
	import pixelPkg::*;

	gameState_e stateQ;
	logic blankQ;
	logic [6:0] rampQ;
	colorIdx_t winIdx;
	rgb_t winRgb;

	// ----------------------------------------
	// stage 1, line up with the layer registers
	// ----------------------------------------
	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset) begin
			stateQ <= stateSelect;
			blankQ <= 1'b0;
			rampQ <= '0;
		end else begin
			stateQ <= gameState;
			blankQ <= blank;
			rampQ <= drawX[CoordW-1:3];
		end
	end

	// ----------------------------------------
	// priority, top layer first
	// ----------------------------------------
	always_comb begin
		winIdx = layers.bgIdx;
		if (stateQ == stateFight && layers.bulletBIdx != KeyIdx) begin
			winIdx = layers.bulletBIdx;
		end else if (stateQ == stateFight && layers.bulletAIdx != KeyIdx) begin
			winIdx = layers.bulletAIdx;
		end else if (layers.tankBIdx != KeyIdx) begin
			winIdx = layers.tankBIdx;
		end else if (layers.tankAIdx != KeyIdx) begin
			winIdx = layers.tankAIdx;
		end
	end

	palette colorLut (
		.colorIdx(winIdx),
		.rgbVal(winRgb)
	);

	// ----------------------------------------
	// stage 2, output register
	// ----------------------------------------
	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset) begin
			Red <= 8'h00;
			Green <= 8'h00;
			Blue <= 8'h00;
		end else begin
			case (stateQ)
				stateSelect, stateFight: begin
					if (!blankQ) begin
						Red <= 8'h00;
						Green <= 8'h00;
						Blue <= 8'h00;
					end else begin
						Red <= winRgb[23:16];
						Green <= winRgb[15:8];
						Blue <= winRgb[7:0];
					end
				end
				default: begin
					// game over ramp fades green across the screen, blank ignored
					Red <= 8'h00;
					Green <= 8'hFF - {1'b0, rampQ};
					Blue <= 8'hFF;
				end
			endcase
		end
	end

endmodule

/* hw/palette.sv */
// palette, 16-entry colour index to 24-bit RGB table
`timescale 1ns/10ps

module palette (
	input pixelPkg::colorIdx_t colorIdx,
	output pixelPkg::rgb_t rgbVal
);

	always_comb begin
		case (colorIdx)
			// slot 0 is the key grey, normally never shown
			4'd0: rgbVal = 24'hB0B0B0;
			4'd1: rgbVal = 24'h2E8B57;
			4'd2: rgbVal = 24'h4169E1;
			4'd3: rgbVal = 24'hB22222;
			4'd4: rgbVal = 24'h8B4513;
			// sky and sand
			4'd5: rgbVal = 24'h87CEEB;
			4'd6: rgbVal = 24'hF5DEB3;
			// tracks and barrel
			4'd7: rgbVal = 24'h1A1A1A;
			4'd8: rgbVal = 24'h303030;
			// bullet shells
			4'd9: rgbVal = 24'hFFD700;
			4'd10: rgbVal = 24'hFF8C00;
			4'd11: rgbVal = 24'hFF00FF;
			4'd12: rgbVal = 24'h00FFFF;
			4'd13: rgbVal = 24'h228B22;
			4'd14: rgbVal = 24'h696969;
			default: rgbVal = 24'hFFFFFF;
		endcase
	end

endmodule

/* hw/pixelPkg.sv */
// pixel pipeline package with screen, sprite and memory constants, shared types and enums
package pixelPkg;

	// ----------------------------------------
	// screen and background memory
	// ----------------------------------------
	localparam int ScreenW = 640;
	localparam int ScreenH = 480;
	localparam int CoordW = $clog2((ScreenW > ScreenH) ? ScreenW : ScreenH);

	// one memory word holds two half-res pixels, i.e. four screen pixels across
	localparam int BgRowWords = ScreenW / 4;
	// wide enough for the last word of the last half-res row
	localparam int BgAddrW = $clog2((ScreenH / 2) * BgRowWords);

	// ----------------------------------------
	// sprites
	// ----------------------------------------
	localparam int TankW = 32;
	localparam int TankH = 16;
	localparam int BulletSize = 8;

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef logic [CoordW-1:0] coord_t;
	typedef logic [3:0] colorIdx_t;
	typedef logic [1:0] tankKind_t;
	typedef logic [23:0] rgb_t;

	// palette slot treated as see-through by every layer
	localparam colorIdx_t KeyIdx = 4'd0;

	// value 3 is not named and falls through to the over screen
	typedef enum logic [1:0] {
		stateSelect = 2'd0,
		stateFight = 2'd1,
		stateOver = 2'd2
	} gameState_e;

	typedef enum logic {
		facingRight = 1'b0,
		facingLeft = 1'b1
	} facing_e;

endpackage

/* hw/tankSprite.sv */
// tank sprite, box hit test and procedural hull shape with facing mirror
`timescale 1ns/10ps

module tankSprite (
	input logic VGA_Clk,
	input logic Reset,
	input pixelPkg::coord_t drawX,
	input pixelPkg::coord_t drawY,
	input pixelPkg::coord_t tankX,
	input pixelPkg::coord_t tankY,
	input pixelPkg::facing_e facing,
	input pixelPkg::tankKind_t tankKind,
	output pixelPkg::colorIdx_t tankIdx
);
	import pixelPkg::*;

	// one extra bit so a pixel left of or above the box shows up as negative
	logic [CoordW:0] dx;
	logic [CoordW:0] dy;
	logic inBox;
	logic [4:0] col;
	logic [3:0] row;
	colorIdx_t bodyIdx;
	colorIdx_t shapeIdx;

	assign dx = {1'b0, drawX} - {1'b0, tankX};
	assign dy = {1'b0, drawY} - {1'b0, tankY};
	assign inBox = !dx[CoordW] && !dy[CoordW] && (dx < TankW) && (dy < TankH);

	// barrel points right by default
	assign col = (facing == facingLeft) ? 5'(TankW - 1) - dx[4:0] : dx[4:0];
	assign row = dy[3:0];
	assign bodyIdx = colorIdx_t'(tankKind) + 4'd1;

	// ----------------------------------------
	// hull shape
	// ----------------------------------------
	always_comb begin
		shapeIdx = KeyIdx;
		if (inBox) begin
			if (row <= 4'd5 && col >= 5'd12 && col <= 5'd19) begin
				// turret
				shapeIdx = bodyIdx;
			end else if (row >= 4'd2 && row <= 4'd3 && col >= 5'd20) begin
				// barrel
				shapeIdx = 4'd8;
			end else if (row >= 4'd6 && row <= 4'd11) begin
				shapeIdx = bodyIdx;
			end else if (row >= 4'd12) begin
				// tracks
				shapeIdx = 4'd7;
			end
		end
	end

	always_ff @(posedge VGA_Clk or posedge Reset) begin
		if (Reset) begin
			tankIdx <= KeyIdx;
		end else begin
			tankIdx <= shapeIdx;
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the colour mapper testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tbColorMapper -Mdir obj_dir -f build.f \
	&& ./obj_dir/VtbColorMapper 2>&1 | tee sim.log \
	|| echo "sim failed" >> sim.log

grep -q "sim failed" sim.log && { echo "result: FAIL"; exit 1; } || { echo "result: PASS"; exit 0; }

/* test/refModel.svh */
// reference model of the colour pipeline, word address, sprite shapes, palette and layer order
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

localparam logic [23:0] RefPalette [16] = '{
	24'hB0B0B0, 24'h2E8B57, 24'h4169E1, 24'hB22222,
	24'h8B4513, 24'h87CEEB, 24'hF5DEB3, 24'h1A1A1A,
	24'h303030, 24'hFFD700, 24'hFF8C00, 24'hFF00FF,
	24'h00FFFF, 24'h228B22, 24'h696969, 24'hFFFFFF
};

function automatic int bgWordAddr(input int x, input int y);
	return (y / 2) * 160 + x / 4;
endfunction

// left half-res pixel of a byte lives in the upper nibble
function automatic int bgNibble(input int x, input int y);
	logic [7:0] b;
	b = bgMem[16'(bgWordAddr(x, y))];
	return ((x / 2) % 2 == 1) ? int'(b[3:0]) : int'(b[7:4]);
endfunction

function automatic int tankIndexAt(input int x, input int y, input int tx, input int ty,
	input int faceLeft, input int kind);
	int dx;
	int dy;
	int c;
	dx = x - tx;
	dy = y - ty;
	if (dx < 0 || dx >= TankW || dy < 0 || dy >= TankH) return 0;
	c = (faceLeft != 0) ? 31 - dx : dx;
	if (dy <= 5 && c >= 12 && c <= 19) return kind + 1;
	if (dy >= 2 && dy <= 3 && c >= 20) return 8;
	if (dy >= 6 && dy <= 11) return kind + 1;
	if (dy >= 12) return 7;
	return 0;
endfunction

function automatic int bulletIndexAt(input int x, input int y, input int bx, input int by,
	input int kind);
	int dx;
	int dy;
	dx = x - bx;
	dy = y - by;
	if (dx < 0 || dx >= BulletSize || dy < 0 || dy >= BulletSize) return 0;
	if ((dx == 0 || dx == 7) && (dy == 0 || dy == 7)) return 0;
	return 9 + kind;
endfunction

// layers applied bottom up, a later nonzero index covers the ones before
function automatic logic [23:0] expectedRgb(input int st, input logic blankIn, input int x,
	input int bgIdx, input int tA, input int tB, input int bA, input int bB);
	int win;
	if (st != 0 && st != 1) return {8'h00, 8'(255 - x / 8), 8'hFF};
	if (!blankIn) return 24'h000000;
	win = bgIdx;
	if (tA != 0) win = tA;
	if (tB != 0) win = tB;
	if (st == 1 && bA != 0) win = bA;
	if (st == 1 && bB != 0) win = bB;
	return RefPalette[4'(win)];
endfunction

`endif

/* test/tbColorMapper.sv */
// testbench for the colour mapper, random scan pixels checked against a reference model
`timescale 1ns/10ps

module tbColorMapper;
	import pixelPkg::*;

	localparam int NumPixels = 20000;
	localparam int RunTimeout = NumPixels + 100;
	localparam int BgBytes = (ScreenH / 2) * BgRowWords;
	localparam int SpriteW [4] = '{TankW, TankW, BulletSize, BulletSize};
	localparam int SpriteH [4] = '{TankH, TankH, BulletSize, BulletSize};

	logic VGA_Clk;
	logic Reset;
	coord_t DrawX;
	coord_t DrawY;
	logic blank;
	gameState_e gameState;
	coord_t TankX_A;
	coord_t TankY_A;
	coord_t TankX_B;
	coord_t TankY_B;
	coord_t BulletX_A;
	coord_t BulletY_A;
	coord_t BulletX_B;
	coord_t BulletY_B;
	facing_e facingA;
	facing_e facingB;
	tankKind_t tankKindA;
	tankKind_t tankKindB;
	logic [7:0] bgData;
	logic [BgAddrW-1:0] bgAddr;
	logic [7:0] Red;
	logic [7:0] Green;
	logic [7:0] Blue;

	logic [7:0] bgMem [BgBytes];
	logic [23:0] expectQ [$];
	int spriteX [4];
	int spriteY [4];
	int seed;
	int cycles;
	int checked;

	`include "refModel.svh"

	// external memory with asynchronous read
	assign bgData = bgMem[16'(bgWordAddr(int'(DrawX), int'(DrawY)))];

	colorMapper uut (
		.VGA_Clk(VGA_Clk), .Reset(Reset), .DrawX(DrawX), .DrawY(DrawY),
		.blank(blank), .gameState(gameState),
		.TankX_A(TankX_A), .TankY_A(TankY_A), .TankX_B(TankX_B), .TankY_B(TankY_B),
		.BulletX_A(BulletX_A), .BulletY_A(BulletY_A),
		.BulletX_B(BulletX_B), .BulletY_B(BulletY_B),
		.facingA(facingA), .facingB(facingB),
		.tankKindA(tankKindA), .tankKindB(tankKindB),
		.bgData(bgData), .bgAddr(bgAddr),
		.Red(Red), .Green(Green), .Blue(Blue)
	);

	initial VGA_Clk = 1'b0;
	always #4 VGA_Clk = ~VGA_Clk;

	function automatic int randBelow(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fffffff) % n;
	endfunction

	task automatic checkEqual(input string what, input logic [31:0] want, input logic [31:0] got);
		assert (got == want) else begin
			$display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, what, want, got);
			$display("sim failed");
			$fatal(1, "%s mismatch", what);
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic newScene();
		for (int i = 0; i < 4; i++) begin
			spriteX[2'(i)] = randBelow(ScreenW - SpriteW[2'(i)]);
			spriteY[2'(i)] = randBelow(ScreenH - SpriteH[2'(i)]);
		end
		TankX_A = coord_t'(spriteX[0]);
		TankY_A = coord_t'(spriteY[0]);
		TankX_B = coord_t'(spriteX[1]);
		TankY_B = coord_t'(spriteY[1]);
		BulletX_A = coord_t'(spriteX[2]);
		BulletY_A = coord_t'(spriteY[2]);
		BulletX_B = coord_t'(spriteX[3]);
		BulletY_B = coord_t'(spriteY[3]);
		facingA = facing_e'(randBelow(2));
		facingB = facing_e'(randBelow(2));
		tankKindA = tankKind_t'(randBelow(4));
		tankKindB = tankKind_t'(randBelow(4));
		gameState = gameState_e'(randBelow(4));
	endtask

	task automatic newPixel();
		int pick;
		int px;
		int py;
		pick = randBelow(8);
		px = randBelow(ScreenW);
		py = randBelow(ScreenH);
		// half the pixels land on or just around a sprite box
		if (pick < 4) begin
			px = spriteX[2'(pick)] + randBelow(SpriteW[2'(pick)] + 2) - 1;
			py = spriteY[2'(pick)] + randBelow(SpriteH[2'(pick)] + 2) - 1;
		end
		DrawX = coord_t'((px < 0) ? 0 : px);
		DrawY = coord_t'((py < 0) ? 0 : py);
		blank = (randBelow(8) != 0);
	endtask

	function automatic logic [23:0] modelPixel();
		int x;
		int y;
		x = int'(DrawX);
		y = int'(DrawY);
		return expectedRgb(int'(gameState), blank, x, bgNibble(x, y),
			tankIndexAt(x, y, spriteX[0], spriteY[0], int'(facingA), int'(tankKindA)),
			tankIndexAt(x, y, spriteX[1], spriteY[1], int'(facingB), int'(tankKindB)),
			bulletIndexAt(x, y, spriteX[2], spriteY[2], int'(tankKindA)),
			bulletIndexAt(x, y, spriteX[3], spriteY[3], int'(tankKindB)));
	endfunction

	task automatic checkOutputs();
		logic [23:0] want;
		checkEqual("bgAddr", 32'(bgWordAddr(int'(DrawX), int'(DrawY))), 32'(bgAddr));
		// two pixels in flight, the older one is due now
		if (expectQ.size() == 2) begin
			want = expectQ.pop_front();
			checkEqual("RGB", 32'(want), 32'({Red, Green, Blue}));
			checked++;
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		seed = 32'h8d7fb75b;
		Reset = 1'b1;
		DrawX = '0;
		DrawY = '0;
		blank = 1'b0;
		gameState = stateSelect;
		spriteX = '{0, 0, 0, 0};
		spriteY = '{0, 0, 0, 0};
		TankX_A = '0;
		TankY_A = '0;
		TankX_B = '0;
		TankY_B = '0;
		BulletX_A = '0;
		BulletY_A = '0;
		BulletX_B = '0;
		BulletY_B = '0;
		facingA = facingRight;
		facingB = facingRight;
		tankKindA = '0;
		tankKindB = '0;
		cycles = 0;
		checked = 0;
		for (int i = 0; i < BgBytes; i++) begin
			bgMem[16'(i)] = 8'($random(seed));
		end

		for (int i = 0; i < 2; i++) begin
			@(posedge VGA_Clk);
			#1;
			checkEqual("RGB during reset", 32'h0, 32'({Red, Green, Blue}));
		end
		Reset = 1'b0;

		// first pixel out still comes from the cleared stage 1 registers
		expectQ.push_back(24'h000000);
		newScene();
		newPixel();
		expectQ.push_back(modelPixel());

		while (checked < NumPixels && cycles < RunTimeout) begin
			@(posedge VGA_Clk);
			#1;
			cycles++;
			checkOutputs();
			if (cycles % 64 == 0) begin
				newScene();
			end
			newPixel();
			expectQ.push_back(modelPixel());
		end

		if (checked < NumPixels) begin
			$display("run timed out after %0d cycles, %0d of %0d pixels checked",
				cycles, checked, NumPixels);
			$display("sim failed");
			$fatal(1, "run did not complete");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

	// watchdog in case the clock or the main loop stalls
	initial begin
		#(8 * (RunTimeout + 50));
		$display("watchdog expired before the run finished");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

endmodule
